// File: hw/decode_pkg.sv
// widths, encodings and packet layouts shared by the decode and issue stage
// rv32i base set only; compressed and M-extension encodings are not decoded

package decode_pkg;

    localparam int xlen       = 32;
    localparam int num_units  = 4;
    localparam int reg_addr_w = 5;

    // execution unit ports, also the issue slot index
    typedef enum logic [1:0] {
        unit_alu,
        unit_branch,
        unit_ls,
        unit_csr
    } unit_e;

    // instruction bits [6:2], bits [1:0] must be 2'b11
    typedef enum logic [4:0] {
        lui       = 5'b01101,
        auipc     = 5'b00101,
        jal       = 5'b11011,
        jalr      = 5'b11001,
        branch    = 5'b11000,
        load      = 5'b00000,
        store     = 5'b01000,
        arith     = 5'b01100,
        arith_imm = 5'b00100,
        system    = 5'b11100
    } opcode_e;

    // fn3 encodings of the arith and branch groups
    localparam logic [2:0] fn3_add_sub = 3'b000;
    localparam logic [2:0] fn3_sll     = 3'b001;
    localparam logic [2:0] fn3_slt     = 3'b010;
    localparam logic [2:0] fn3_sltu    = 3'b011;
    localparam logic [2:0] fn3_xor     = 3'b100;
    localparam logic [2:0] fn3_sr      = 3'b101;  // srl and sra
    localparam logic [2:0] fn3_or      = 3'b110;
    localparam logic [2:0] fn3_and     = 3'b111;
    localparam logic [2:0] fn3_bltu    = 3'b110;
    localparam logic [2:0] fn3_bgeu    = 3'b111;

    typedef enum logic [1:0] {
        alu_add_sub,
        alu_slt,
        alu_shift,
        alu_logic
    } alu_op_e;

    typedef enum logic [1:0] {
        logic_add,
        logic_xor,
        logic_or,
        logic_and
    } alu_logic_e;

    typedef struct packed {
        logic [31:0]     instr;
        logic [xlen-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
    } rf_read_t;

    typedef struct packed {
        logic subtract;
        logic lshift;
        logic arith;        // shift-in bit for sra
        logic use_signed;
        logic jal;
        logic jalr;
        logic load;
        logic store;
        logic rs1_is_zero;
        logic rd_is_zero;
    } ctrl_t;

    typedef struct packed {
        logic [xlen:0]   in1;   // extra top bit for signed compare
        logic [xlen:0]   in2;
        logic [xlen-1:0] aux;   // shifter input, ls offset or csr address
        logic [xlen-1:0] pc;
        logic [2:0]      fn3;
        ctrl_t           ctrl;
        alu_op_e         alu_op;
        alu_logic_e      logic_op;
    } issue_packet_t;

endpackage

// File: hw/instr_decode.sv
// combinational decode of one rv32i instruction into a unit select and packet
// ecall, ebreak, fence and every M-extension encoding report illegal
// packet fields not used by the selected unit are left at zero

`timescale 1ns/1ns

module instr_decode (
    input  decode_pkg::fetch_t                fetch,
    input  decode_pkg::rf_read_t              rf_data,
    output logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rd_addr,
    output logic                              uses_rs1,
    output logic                              uses_rs2,
    output logic                              writes_rd,
    output logic [decode_pkg::num_units-1:0]  unit_sel,
    output logic                              illegal_instr,
    output decode_pkg::issue_packet_t         packet
);

    logic [31:0]                 instr;
    logic [2:0]                  fn3;
    decode_pkg::opcode_e         opcode;
    logic                        upper_op;  // lui or auipc
    logic [decode_pkg::xlen-1:0] rs1;
    logic [decode_pkg::xlen-1:0] rs2;
    logic [decode_pkg::xlen-1:0] imm_i;
    logic [decode_pkg::xlen-1:0] imm_s;
    logic [decode_pkg::xlen-1:0] imm_u;
    logic [decode_pkg::xlen-1:0] alu_a;
    logic [decode_pkg::xlen-1:0] alu_b;
    logic [decode_pkg::xlen-1:0] rs1_rev;
    logic [decode_pkg::xlen-1:0] csr_src;
    logic                        sign_ext;
    decode_pkg::alu_op_e         alu_op;
    decode_pkg::alu_logic_e      logic_op;

    assign instr    = fetch.instr;
    assign fn3      = instr[14:12];
    assign opcode   = decode_pkg::opcode_e'(instr[6:2]);
    assign upper_op = opcode inside {decode_pkg::lui, decode_pkg::auipc};
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];
    assign rs1      = rf_data.rs1_data;
    assign rs2      = rf_data.rs2_data;

    assign imm_i = {{(decode_pkg::xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(decode_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    //------------------------------------------------------------------
    // unit selection
    //------------------------------------------------------------------
    always_comb begin
        unit_sel = '0;
        if (instr[1:0] == 2'b11) begin
            case (opcode)
                decode_pkg::arith: unit_sel[decode_pkg::unit_alu] = ~instr[25];  // M bit
                decode_pkg::arith_imm,
                decode_pkg::lui,
                decode_pkg::auipc: unit_sel[decode_pkg::unit_alu] = 1'b1;
                decode_pkg::branch,
                decode_pkg::jal,
                decode_pkg::jalr: unit_sel[decode_pkg::unit_branch] = 1'b1;
                decode_pkg::load,
                decode_pkg::store: unit_sel[decode_pkg::unit_ls] = 1'b1;
                decode_pkg::system: unit_sel[decode_pkg::unit_csr] = (fn3 != 3'b000);
                default: ;
            endcase
        end
    end

    assign illegal_instr = ~|unit_sel;

    assign uses_rs1 = (unit_sel[decode_pkg::unit_alu] & ~upper_op)
                    | (unit_sel[decode_pkg::unit_branch] & (opcode != decode_pkg::jal))
                    | unit_sel[decode_pkg::unit_ls]
                    | (unit_sel[decode_pkg::unit_csr] & ~fn3[2]);  // csr imm form
    assign uses_rs2 = (unit_sel[decode_pkg::unit_alu] & (opcode == decode_pkg::arith))
                    | (unit_sel[decode_pkg::unit_branch] & (opcode == decode_pkg::branch))
                    | (unit_sel[decode_pkg::unit_ls] & (opcode == decode_pkg::store));
    assign writes_rd = ~illegal_instr && (rd_addr != '0)
                     && !(opcode inside {decode_pkg::branch, decode_pkg::store});

    //------------------------------------------------------------------
    // alu operand selection
    //------------------------------------------------------------------
    assign alu_a = (opcode == decode_pkg::lui) ? '0 :
                   (opcode == decode_pkg::auipc) ? fetch.pc : rs1;
    assign alu_b = upper_op ? imm_u :
                   (opcode == decode_pkg::arith_imm) ? imm_i : rs2;
    assign sign_ext = (fn3 != decode_pkg::fn3_sltu);
    assign csr_src  = fn3[2] ? {{(decode_pkg::xlen-decode_pkg::reg_addr_w){1'b0}}, rs1_addr}
                             : rs1;

    always_comb begin
        for (int i = 0; i < decode_pkg::xlen; i++) begin
            rs1_rev[i] = rs1[decode_pkg::xlen-1-i];  // sll runs on the right shifter
        end
    end

    always_comb begin
        alu_op   = decode_pkg::alu_add_sub;
        logic_op = decode_pkg::logic_add;
        case (fn3)
            decode_pkg::fn3_sll,
            decode_pkg::fn3_sr: alu_op = decode_pkg::alu_shift;
            decode_pkg::fn3_slt,
            decode_pkg::fn3_sltu: alu_op = decode_pkg::alu_slt;
            decode_pkg::fn3_xor: begin
                alu_op   = decode_pkg::alu_logic;
                logic_op = decode_pkg::logic_xor;
            end
            decode_pkg::fn3_or: begin
                alu_op   = decode_pkg::alu_logic;
                logic_op = decode_pkg::logic_or;
            end
            decode_pkg::fn3_and: begin
                alu_op   = decode_pkg::alu_logic;
                logic_op = decode_pkg::logic_and;
            end
            default: ;
        endcase
        if (upper_op) begin  // lui and auipc go through the adder
            alu_op   = decode_pkg::alu_add_sub;
            logic_op = decode_pkg::logic_add;
        end
    end

    //------------------------------------------------------------------
    // packet per selected unit
    //------------------------------------------------------------------
    always_comb begin
        packet     = '0;
        packet.pc  = fetch.pc;
        packet.fn3 = fn3;
        if (unit_sel[decode_pkg::unit_alu]) begin
            packet.in1 = {alu_a[decode_pkg::xlen-1] & sign_ext, alu_a};
            packet.in2 = {alu_b[decode_pkg::xlen-1] & sign_ext, alu_b};
            packet.aux = fn3[2] ? rs1 : rs1_rev;
            packet.ctrl.subtract = ~upper_op && ((fn3 inside {decode_pkg::fn3_slt,
                decode_pkg::fn3_sltu}) || ((fn3 == decode_pkg::fn3_add_sub) && instr[30]
                && (opcode == decode_pkg::arith)));
            packet.ctrl.arith  = rs1[decode_pkg::xlen-1] & instr[30];
            packet.ctrl.lshift = ~fn3[2];
            packet.alu_op      = alu_op;
            packet.logic_op    = logic_op;
        end else if (unit_sel[decode_pkg::unit_branch]) begin
            packet.in1 = {1'b0, rs1};
            packet.in2 = {1'b0, rs2};
            packet.ctrl.use_signed = !(fn3 inside {decode_pkg::fn3_bltu, decode_pkg::fn3_bgeu});
            packet.ctrl.jal  = (opcode == decode_pkg::jal);
            packet.ctrl.jalr = (opcode == decode_pkg::jalr);
        end else if (unit_sel[decode_pkg::unit_ls]) begin
            packet.in1 = {1'b0, rs1};
            packet.in2 = {1'b0, rs2};
            packet.aux = (opcode == decode_pkg::store) ? imm_s : imm_i;
            packet.ctrl.load  = (opcode == decode_pkg::load);
            packet.ctrl.store = (opcode == decode_pkg::store);
        end else if (unit_sel[decode_pkg::unit_csr]) begin
            packet.in1 = {1'b0, csr_src};
            packet.aux = {{(decode_pkg::xlen-12){1'b0}}, instr[31:20]};  // csr address
            packet.ctrl.rs1_is_zero = (rs1_addr == '0);
            packet.ctrl.rd_is_zero  = (rd_addr == '0);
        end
    end

endmodule

// File: hw/reg_scoreboard.sv
// busy bit per architectural register, set at issue and cleared at writeback
// only source operands are checked, no write-after-write tracking

`timescale 1ns/1ns

module reg_scoreboard (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              advance,
    input  logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [decode_pkg::reg_addr_w-1:0] rd_addr,
    input  logic                              uses_rs1,
    input  logic                              uses_rs2,
    input  logic                              writes_rd,
    input  logic                              wb_valid,
    input  logic [decode_pkg::reg_addr_w-1:0] wb_rd,
    output logic                              operands_ready
);

    logic [2**decode_pkg::reg_addr_w-1:0] busy;
    logic                                 rs1_conflict;
    logic                                 rs2_conflict;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
            // issued after the clear so a same-edge set wins
            if (advance && writes_rd && (rd_addr != '0)) begin
                busy[rd_addr] <= 1'b1;
            end
        end
    end

    // no bypass from a writeback in the same cycle
    assign rs1_conflict   = uses_rs1 & busy[rs1_addr];
    assign rs2_conflict   = uses_rs2 & busy[rs2_addr];
    assign operands_ready = ~(rs1_conflict | rs2_conflict);

endmodule

// File: hw/issue_slot.sv
// one execution-unit port, req is a single-cycle pulse one cycle after issue
// packet_out holds its value until the next issue to this unit

`timescale 1ns/1ns

module issue_slot (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sel,
    input  logic                      unit_ready,
    input  logic                      advance,
    input  decode_pkg::issue_packet_t packet_in,
    output logic                      accept,
    output logic                      req,
    output decode_pkg::issue_packet_t packet_out
);

    logic issue;

    assign accept = sel & unit_ready;
    assign issue  = advance & accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            req <= 1'b0;
        end else begin
            req <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            packet_out <= packet_in;
        end
    end

endmodule

// File: hw/issue_controller.sv
// advance decision for the decode stage and the registered illegal report
// illegal instructions are dropped at once, independent of unit or operand state

`timescale 1ns/1ns

module issue_controller (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instr_valid,
    input  logic [decode_pkg::num_units-1:0] accept,
    input  logic                             operands_ready,
    input  logic                             illegal_instr,
    input  logic [decode_pkg::xlen-1:0]      pc,
    output logic                             advance,
    output logic                             illegal,
    output logic [decode_pkg::xlen-1:0]      illegal_pc
);

    logic legal_go;
    logic illegal_go;

    assign legal_go   = (|accept) & operands_ready;  // accept is zero when illegal
    assign illegal_go = instr_valid & illegal_instr;
    assign advance    = instr_valid & (illegal_instr | legal_go);

    always_ff @(posedge clk) begin
        if (rst) begin
            illegal <= 1'b0;
        end else begin
            illegal <= illegal_go;
        end
    end

    always_ff @(posedge clk) begin
        if (illegal_go) begin
            illegal_pc <= pc;  // held for the pulse
        end
    end

endmodule

// File: hw/decode_issue.sv
// decode and issue stage for an in-order rv32i core, one instruction per cycle
// register file is external and must answer rs1_addr/rs2_addr in the same cycle
// unit_req and unit_packet follow acceptance by exactly one cycle

`timescale 1ns/1ns

module decode_issue (
    input  logic                              clk,
    input  logic                              rst,
    input  decode_pkg::fetch_t                fetch,
    input  logic                              instr_valid,
    output logic                              instr_ready,
    output logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    input  decode_pkg::rf_read_t              rf_data,
    input  logic                              wb_valid,
    input  logic [decode_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [decode_pkg::num_units-1:0]  unit_ready,
    output logic [decode_pkg::num_units-1:0]  unit_req,
    output decode_pkg::issue_packet_t         unit_packet [decode_pkg::num_units],
    output logic                              illegal,
    output logic [decode_pkg::xlen-1:0]       illegal_pc
);

    logic [decode_pkg::reg_addr_w-1:0] rd_addr;
    logic                              uses_rs1;
    logic                              uses_rs2;
    logic                              writes_rd;
    logic [decode_pkg::num_units-1:0]  unit_sel;
    logic [decode_pkg::num_units-1:0]  accept;
    logic                              illegal_instr;
    logic                              operands_ready;
    logic                              advance;
    decode_pkg::issue_packet_t         packet;

    instr_decode instr_decode_i (
        .fetch         (fetch),
        .rf_data       (rf_data),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd_addr       (rd_addr),
        .uses_rs1      (uses_rs1),
        .uses_rs2      (uses_rs2),
        .writes_rd     (writes_rd),
        .unit_sel      (unit_sel),
        .illegal_instr (illegal_instr),
        .packet        (packet)
    );

    reg_scoreboard reg_scoreboard_i (
        .clk            (clk),
        .rst            (rst),
        .advance        (advance),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rd_addr        (rd_addr),
        .uses_rs1       (uses_rs1),
        .uses_rs2       (uses_rs2),
        .writes_rd      (writes_rd),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .operands_ready (operands_ready)
    );

    //------------------------------------------------------------------
    // one slot per execution unit, indexed by unit_e
    //------------------------------------------------------------------
    for (genvar u = 0; u < decode_pkg::num_units; u++) begin : g_slot
        issue_slot issue_slot_i (
            .clk        (clk),
            .rst        (rst),
            .sel        (unit_sel[u]),
            .unit_ready (unit_ready[u]),
            .advance    (advance),
            .packet_in  (packet),
            .accept     (accept[u]),
            .req        (unit_req[u]),
            .packet_out (unit_packet[u])
        );
    end

    issue_controller issue_controller_i (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .accept         (accept),
        .operands_ready (operands_ready),
        .illegal_instr  (illegal_instr),
        .pc             (fetch.pc),
        .advance        (advance),
        .illegal        (illegal),
        .illegal_pc     (illegal_pc)
    );

    assign instr_ready = advance;  // pop of the fetch side

endmodule

// File: test/decode_issue_properties.sv
// concurrent checks on the issue outputs of decode_issue
// sampled on the rising edge and mostly disabled while rst is high

`timescale 1ns/1ns

module decode_issue_properties (
    input logic                             clk,
    input logic                             rst,
    input logic                             instr_valid,
    input logic                             instr_ready,
    input logic [decode_pkg::num_units-1:0] unit_req,
    input logic                             illegal
);

    int fail_count = 0;

    req_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(unit_req))
        else begin
            fail_count++;
            $error("more than one unit_req bit high");
        end

    req_or_illegal: assert property (@(posedge clk) disable iff (rst)
        !((|unit_req) && illegal))
        else begin
            fail_count++;
            $error("unit_req and illegal high in the same cycle");
        end

    // a request needs a fetch handshake one cycle earlier
    req_after_pop: assert property (@(posedge clk) disable iff (rst)
        (|unit_req) |-> $past(instr_valid && instr_ready))
        else begin
            fail_count++;
            $error("unit_req without a consumed instruction");
        end

    quiet_after_reset: assert property (@(posedge clk) (!rst && $past(rst)) |-> unit_req == '0)
        else begin
            fail_count++;
            $error("unit_req in the first cycle after reset");
        end

endmodule

bind decode_issue decode_issue_properties decode_issue_properties_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .unit_req    (unit_req),
    .illegal     (illegal)
);

// File: test/decode_issue_tb.sv
// random and directed stimulus for the decode and issue stage
// register file model gives a fixed pseudo-random word per address and x0 reads zero
// one instruction is in flight at a time so throughput is not measured

`timescale 1ns/1ns

module decode_issue_tb;

    localparam int num_random  = 40;  // per instruction group
    localparam int total_instr = 2 * num_random + 10;

    typedef struct packed {
        logic                      illegal;
        decode_pkg::unit_e         unit;
        decode_pkg::issue_packet_t pkt;
    } expect_t;

    logic                              clk;
    logic                              rst;
    decode_pkg::fetch_t                fetch;
    logic                              instr_valid;
    logic                              instr_ready;
    logic [decode_pkg::reg_addr_w-1:0] rs1_addr;
    logic [decode_pkg::reg_addr_w-1:0] rs2_addr;
    decode_pkg::rf_read_t              rf_data;
    logic                              wb_valid;
    logic [decode_pkg::reg_addr_w-1:0] wb_rd;
    logic [decode_pkg::num_units-1:0]  unit_ready;
    logic [decode_pkg::num_units-1:0]  unit_req;
    decode_pkg::issue_packet_t         unit_packet [decode_pkg::num_units];
    logic                              illegal;
    logic [decode_pkg::xlen-1:0]       illegal_pc;

    logic [31:0] rng;
    logic [31:0] pc_next;
    string       test_name;
    logic        pending;
    string       pending_name;
    expect_t     expected;

    decode_pkg::opcode_e alu_ops [4] = '{decode_pkg::arith, decode_pkg::arith_imm,
                                         decode_pkg::lui, decode_pkg::auipc};
    decode_pkg::opcode_e other_ops [6] = '{decode_pkg::branch, decode_pkg::jal,
        decode_pkg::jalr, decode_pkg::load, decode_pkg::store, decode_pkg::system};
    // unknown opcode, mul, fence, ecall and a compressed word
    logic [31:0] illegal_words [5] = '{32'h0000_000b, 32'h0220_81b3, 32'h0ff0_000f,
                                       32'h0000_0073, 32'h0000_4501};

    decode_issue decode_issue_i (.*);

    assign rf_data = {rf_value(rs1_addr), rf_value(rs2_addr)};  // same-cycle read

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // value of register addr is step addr+1 of the seed 25 sequence
    function automatic logic [31:0] rf_value(input logic [4:0] addr);
        logic [31:0] v;
        v = 32'd25;
        if (addr == 5'd0) begin
            return '0;
        end
        for (int k = 0; k <= addr; k++) begin
            v = xorshift(v);
        end
        return v;
    endfunction

    function automatic logic [31:0] make_instr(input decode_pkg::opcode_e op,
                                               input logic [31:0] rnd);
        logic [31:0] w;
        w      = rnd;
        w[6:0] = {op, 2'b11};
        if (op == decode_pkg::arith) begin
            w[25] = 1'b0;  // keep clear of the M extension
        end
        if (op == decode_pkg::system && w[14:12] == 3'b000) begin
            w[14:12] = 3'b001;  // csrrw instead of ecall
        end
        return w;
    endfunction

    //----------------------------------------------------------------------
    // expected unit and packet
    //----------------------------------------------------------------------
    function automatic expect_t predict(input logic [31:0] instr, input logic [31:0] pc);
        expect_t     e;
        logic [4:0]  op;
        logic [2:0]  f3;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rev;
        logic [31:0] imm_i;
        logic        upper;
        logic        sx;
        op    = instr[6:2];
        f3    = instr[14:12];
        s1    = rf_value(instr[19:15]);
        s2    = rf_value(instr[24:20]);
        rev   = {<<{s1}};
        imm_i = {{20{instr[31]}}, instr[31:20]};
        upper = (op == decode_pkg::lui) || (op == decode_pkg::auipc);
        e         = '0;
        e.illegal = 1'b1;
        e.pkt.pc  = pc;
        e.pkt.fn3 = f3;
        if (instr[1:0] == 2'b11) begin
            case (op)
                decode_pkg::arith, decode_pkg::arith_imm, decode_pkg::lui, decode_pkg::auipc:
                if (!(op == decode_pkg::arith && instr[25])) begin
                    e.illegal = 1'b0;
                    e.unit    = decode_pkg::unit_alu;
                    a  = (op == decode_pkg::lui) ? '0 : (op == decode_pkg::auipc) ? pc : s1;
                    b  = upper ? {instr[31:12], 12'b0}
                               : (op == decode_pkg::arith_imm) ? imm_i : s2;
                    sx = (f3 != 3'b011);  // sltu compares unsigned
                    e.pkt.in1 = {sx & a[31], a};
                    e.pkt.in2 = {sx & b[31], b};
                    e.pkt.aux = f3[2] ? s1 : rev;
                    e.pkt.ctrl.subtract = !upper && (f3 == 3'b010 || f3 == 3'b011
                        || (op == decode_pkg::arith && f3 == 3'b000 && instr[30]));
                    e.pkt.ctrl.arith  = s1[31] & instr[30];
                    e.pkt.ctrl.lshift = !f3[2];
                    if (!upper) begin
                        case (f3)
                            3'b001, 3'b101: e.pkt.alu_op = decode_pkg::alu_shift;
                            3'b010, 3'b011: e.pkt.alu_op = decode_pkg::alu_slt;
                            3'b100: begin
                                e.pkt.alu_op   = decode_pkg::alu_logic;
                                e.pkt.logic_op = decode_pkg::logic_xor;
                            end
                            3'b110: begin
                                e.pkt.alu_op   = decode_pkg::alu_logic;
                                e.pkt.logic_op = decode_pkg::logic_or;
                            end
                            3'b111: begin
                                e.pkt.alu_op   = decode_pkg::alu_logic;
                                e.pkt.logic_op = decode_pkg::logic_and;
                            end
                            default: ;
                        endcase
                    end
                end
                decode_pkg::branch, decode_pkg::jal, decode_pkg::jalr: begin
                    e.illegal = 1'b0;
                    e.unit    = decode_pkg::unit_branch;
                    e.pkt.in1 = {1'b0, s1};
                    e.pkt.in2 = {1'b0, s2};
                    e.pkt.ctrl.use_signed = (f3[2:1] != 2'b11);  // not bltu or bgeu
                    e.pkt.ctrl.jal  = (op == decode_pkg::jal);
                    e.pkt.ctrl.jalr = (op == decode_pkg::jalr);
                end
                decode_pkg::load, decode_pkg::store: begin
                    e.illegal = 1'b0;
                    e.unit    = decode_pkg::unit_ls;
                    e.pkt.in1 = {1'b0, s1};
                    e.pkt.in2 = {1'b0, s2};
                    e.pkt.aux = (op == decode_pkg::store)
                              ? {{20{instr[31]}}, instr[31:25], instr[11:7]} : imm_i;
                    e.pkt.ctrl.load  = (op == decode_pkg::load);
                    e.pkt.ctrl.store = (op == decode_pkg::store);
                end
                decode_pkg::system: if (f3 != 3'b000) begin
                    e.illegal = 1'b0;
                    e.unit    = decode_pkg::unit_csr;
                    e.pkt.in1 = {1'b0, f3[2] ? {27'b0, instr[19:15]} : s1};
                    e.pkt.aux = {20'b0, instr[31:20]};  // csr address
                    e.pkt.ctrl.rs1_is_zero = (instr[19:15] == 5'd0);
                    e.pkt.ctrl.rd_is_zero  = (instr[11:7] == 5'd0);
                end
                default: ;
            endcase
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [159:0] exp_val,
                               input logic [159:0] act_val);
        if (exp_val !== act_val) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp_val, act_val);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // called on a rising edge
    task automatic present(input logic [31:0] instr);
        fetch       <= '{instr: instr, pc: pc_next};
        instr_valid <= 1'b1;
    endtask

    task automatic complete(input logic do_wb, input logic no_wait);
        @(negedge clk);
        if (no_wait) begin
            check_value({test_name, "_ready"}, 1'b1, instr_ready);
        end
        while (!instr_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // consumed at this edge
        instr_valid <= 1'b0;
        pc_next     <= pc_next + 32'd4;
        wb_valid    <= do_wb;
        wb_rd       <= fetch.instr[11:7];  // clears the rd just marked busy
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    //----------------------------------------------------------------------
    // compare one cycle after each consumed instruction
    //----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst) begin
            pending = 1'b0;
        end else begin
            if (pending && expected.illegal) begin
                check_value(pending_name, 5'b0_0001, {unit_req, illegal});
                check_value({pending_name, "_pc"}, expected.pkt.pc, illegal_pc);
            end else if (pending) begin
                check_value(pending_name, {(4'b0001 << expected.unit), 1'b0},
                            {unit_req, illegal});
                check_value({pending_name, "_packet"}, expected.pkt,
                            unit_packet[expected.unit]);
            end else begin
                check_value({test_name, "_idle"}, '0, {unit_req, illegal});
            end
            pending = instr_valid && instr_ready;  // taken at the coming edge
            if (pending) begin
                expected     = predict(fetch.instr, fetch.pc);
                pending_name = test_name;
            end
        end
    end

    always @(negedge clk) begin
        if (decode_issue_i.decode_issue_properties_i.fail_count != 0) begin
            $display("a bound assertion on the issue outputs failed");
            $display(">>> FAIL");
            $fatal(1, "stopped at the first error");
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (total_instr * 20) @(posedge clk);
        $display("watchdog expired after %0d cycles before the test list ended",
                 total_instr * 20);
        $display(">>> FAIL");
        $fatal(1, "watchdog");
    end

    initial begin
        rst         = 1'b1;
        fetch       = '0;
        instr_valid = 1'b0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        unit_ready  = '1;
        rng         = 32'd25;
        pc_next     = 32'h0000_1000;
        test_name   = "reset";
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_name = "alu_random";
        for (int i = 0; i < num_random; i++) begin
            rng = xorshift(rng);
            present(make_instr(alu_ops[rng % 4], rng));
            complete(1'b1, 1'b0);
        end
        test_name = "other_units_random";
        for (int i = 0; i < num_random; i++) begin
            rng = xorshift(rng);
            present(make_instr(other_ops[rng % 6], rng));
            complete(1'b1, 1'b0);
        end

        // alu port busy holds the instruction
        test_name  = "unit_not_ready";
        unit_ready <= 4'b1110;
        present(make_instr(decode_pkg::arith_imm, 32'h0123_4567));
        repeat (4) begin
            @(negedge clk);
            check_value(test_name, 1'b0, instr_ready);
        end
        @(posedge clk);
        unit_ready <= 4'b1111;
        complete(1'b1, 1'b0);

        test_name = "raw_hazard";
        present(32'h0050_0293);  // addi x5, x0, 5
        complete(1'b0, 1'b0);
        present(32'h0012_8333);  // add x6, x5, x1
        repeat (4) begin
            @(negedge clk);
            check_value(test_name, 1'b0, instr_ready);
        end
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_rd    <= 5'd5;
        @(posedge clk);
        wb_valid <= 1'b0;
        complete(1'b1, 1'b0);

        test_name = "x0_no_block";
        present(32'h0010_8013);  // addi x0, x1, 1
        complete(1'b0, 1'b0);
        present(32'h0000_03b3);  // add x7, x0, x0
        complete(1'b1, 1'b1);

        test_name  = "illegal";
        unit_ready <= 4'b0000;
        for (int i = 0; i < 5; i++) begin
            present(illegal_words[i]);
            complete(1'b0, 1'b1);
        end
        unit_ready <= 4'b1111;

        repeat (2) @(negedge clk);
        if (decode_issue_i.decode_issue_properties_i.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d assertion failures on the issue outputs",
                     decode_issue_i.decode_issue_properties_i.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// File: list.f
hw/decode_pkg.sv
hw/instr_decode.sv
hw/reg_scoreboard.sv
hw/issue_slot.sv
hw/issue_controller.sv
hw/decode_issue.sv
test/decode_issue_properties.sv
test/decode_issue_tb.sv
